// File: include/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// Entries per reservation station
`define RS_DEPTH 4

// Any other opcode goes to the add unit
`define OPC_MUL 7'b0110011
`define OPC_DIV 7'b1001111

// Incoming ALU op that selects remainder on the div unit
`define DIV_REM_ALUOP 4'b1011

`endif

// File: hdl/uop_pkg.sv
package uop_pkg;

    typedef logic [31:0] word_t;   // Data or address
    typedef logic [7:0]  preg_t;   // Physical register tag
    typedef logic [2:0]  func3_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [6:0]  opcode_t;

    typedef struct packed {
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        alu_op_t alu_op;
        logic    alu_src1;         // Pc instead of operand1
        logic    alu_src2;         // Immediate instead of operand2
        logic    jump;
        logic    branch;
    } ctrl_t;

    typedef struct packed {
        opcode_t    opcode;
        word_t      operand1;
        word_t      operand2;
        func3_t     func3;
        word_t      pc;
        preg_t      rd;
        preg_t      src1_tag;
        preg_t      src2_tag;
        logic [1:0] ready;         // Bit 0 operand1, bit 1 operand2
        word_t      immediate;
        ctrl_t      ctrl;
    } uop_t;

endpackage

// File: hdl/unit_pkg.sv
package unit_pkg;

    typedef enum logic [1:0] {
        UNIT_ADD,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    typedef struct packed {
        logic          occupied;
        uop_pkg::uop_t uop;
    } rs_entry_t;

    typedef struct packed {
        uop_pkg::preg_t tag;
        uop_pkg::word_t data;
    } cdb_t;

    typedef struct packed {
        uop_pkg::word_t  alu_a;
        uop_pkg::word_t  alu_b;
        uop_pkg::func3_t func3;
        uop_pkg::word_t  pc;
        uop_pkg::preg_t  rd;
        uop_pkg::word_t  immediate;
        uop_pkg::ctrl_t  ctrl;
    } issue_t;

endpackage

// File: hdl/dispatch_decoder.sv
`include "dispatch_consts.svh"

module dispatch_decoder (
    input  logic          dispatch_valid,
    input  uop_pkg::uop_t dispatch_uop,
    output logic          add_write,
    output logic          mul_write,
    output logic          div_write,
    output uop_pkg::uop_t station_uop
);
    import uop_pkg::*;
    import unit_pkg::*;

    unit_e unit;

    always_comb begin
        case (dispatch_uop.opcode)
            `OPC_MUL: begin
                unit = UNIT_MUL;
            end
            `OPC_DIV: begin
                unit = UNIT_DIV;
            end
            default: begin
                unit = UNIT_ADD;
            end
        endcase
    end

    assign add_write = dispatch_valid && (unit == UNIT_ADD);
    assign mul_write = dispatch_valid && (unit == UNIT_MUL);
    assign div_write = dispatch_valid && (unit == UNIT_DIV);

    // Div unit only knows divide and remainder
    always_comb begin
        station_uop = dispatch_uop;
        if (unit == UNIT_DIV) begin
            if (dispatch_uop.ctrl.alu_op == alu_op_t'(`DIV_REM_ALUOP)) begin
                station_uop.ctrl.alu_op = 4'b0001;   // Remainder
            end else begin
                station_uop.ctrl.alu_op = 4'b0000;   // Quotient
            end
        end
    end

endmodule

// File: hdl/reservation_station.sv
`include "dispatch_consts.svh"

module reservation_station (
    input  logic           clk,
    input  logic           reset,
    input  logic           write,
    input  uop_pkg::uop_t  write_uop,
    input  logic           cdb_valid,
    input  unit_pkg::cdb_t cdb,
    input  logic           take,
    output logic           full,
    output logic           pick_valid,
    output uop_pkg::uop_t  pick_uop
);
    import uop_pkg::*;
    import unit_pkg::*;

    localparam int IDX_W = (`RS_DEPTH > 1) ? $clog2(`RS_DEPTH) : 1;

    rs_entry_t            entry_q [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] occupied;
    logic [`RS_DEPTH-1:0] ready_vec;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     pick_idx;

    // Capture a broadcast result into any operand still waiting on its tag
    function automatic uop_t wake(input uop_t u, input logic hit, input cdb_t bus);
        uop_t w;
        w = u;
        if (hit && !u.ready[0] && (u.src1_tag == bus.tag)) begin
            w.operand1 = bus.data;
            w.ready[0] = 1'b1;
        end
        if (hit && !u.ready[1] && (u.src2_tag == bus.tag)) begin
            w.operand2 = bus.data;
            w.ready[1] = 1'b1;
        end
        return w;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            occupied[i]  = entry_q[i].occupied;
            ready_vec[i] = entry_q[i].occupied && (entry_q[i].uop.ready == 2'b11);
        end
    end

    // Lowest index wins for both the free slot and the pick
    always_comb begin
        free_idx   = '0;
        pick_idx   = '0;
        pick_valid = 1'b0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_idx = IDX_W'(i);
            end
            if (ready_vec[i]) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(i);
            end
        end
    end

    assign full     = &occupied;
    assign pick_uop = entry_q[pick_idx].uop;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entry_q[i].uop <= wake(entry_q[i].uop, cdb_valid, cdb);
        end
        if (write && !full) begin
            entry_q[free_idx].uop <= wake(write_uop, cdb_valid, cdb);   // Same-cycle wakeup
        end

        if (reset) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                entry_q[i].occupied <= 1'b0;
            end
        end else begin
            if (take && pick_valid) begin
                entry_q[pick_idx].occupied <= 1'b0;
            end
            if (write && !full) begin
                entry_q[free_idx].occupied <= 1'b1;   // Never the picked slot
            end
        end
    end

endmodule

// File: hdl/issue_stage.sv
module issue_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             add_pick_valid,
    input  logic             mul_pick_valid,
    input  logic             div_pick_valid,
    input  uop_pkg::uop_t    add_pick_uop,
    input  uop_pkg::uop_t    mul_pick_uop,
    input  uop_pkg::uop_t    div_pick_uop,
    output logic             add_take,
    output logic             mul_take,
    output logic             div_take,
    output logic             add_issue_valid,
    output logic             mul_issue_valid,
    output logic             div_issue_valid,
    output unit_pkg::issue_t add_issue,
    output unit_pkg::issue_t mul_issue,
    output unit_pkg::issue_t div_issue
);
    import uop_pkg::*;
    import unit_pkg::*;

    function automatic issue_t build_issue(input uop_t u);
        issue_t p;
        p.alu_a     = u.ctrl.alu_src1 ? u.pc : u.operand1;
        p.alu_b     = u.ctrl.alu_src2 ? u.immediate : u.operand2;
        p.func3     = u.func3;
        p.pc        = u.pc;
        p.rd        = u.rd;
        p.immediate = u.immediate;
        p.ctrl      = u.ctrl;
        return p;
    endfunction

    // No stall downstream, so every pick is taken
    assign add_take = add_pick_valid;
    assign mul_take = mul_pick_valid;
    assign div_take = div_pick_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            add_issue_valid <= 1'b0;
            mul_issue_valid <= 1'b0;
            div_issue_valid <= 1'b0;
            add_issue       <= '0;
            mul_issue       <= '0;
            div_issue       <= '0;
        end else begin
            add_issue_valid <= add_pick_valid;
            mul_issue_valid <= mul_pick_valid;
            div_issue_valid <= div_pick_valid;
            if (add_pick_valid) begin
                add_issue <= build_issue(add_pick_uop);
            end
            if (mul_pick_valid) begin
                mul_issue <= build_issue(mul_pick_uop);
            end
            if (div_pick_valid) begin
                div_issue <= build_issue(div_pick_uop);
            end
        end
    end

endmodule

// File: hdl/dispatch_top.sv
module dispatch_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  uop_pkg::uop_t    dispatch_uop,
    input  logic             cdb_valid,
    input  unit_pkg::cdb_t   cdb,
    output logic             add_full,
    output logic             mul_full,
    output logic             div_full,
    output logic             add_issue_valid,
    output logic             mul_issue_valid,
    output logic             div_issue_valid,
    output unit_pkg::issue_t add_issue,
    output unit_pkg::issue_t mul_issue,
    output unit_pkg::issue_t div_issue
);
    import uop_pkg::*;

    logic add_write;
    logic mul_write;
    logic div_write;
    uop_t station_uop;

    logic add_pick_valid;
    logic mul_pick_valid;
    logic div_pick_valid;
    uop_t add_pick_uop;
    uop_t mul_pick_uop;
    uop_t div_pick_uop;
    logic add_take;
    logic mul_take;
    logic div_take;

    dispatch_decoder u_decoder (
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .add_write      (add_write),
        .mul_write      (mul_write),
        .div_write      (div_write),
        .station_uop    (station_uop)
    );

    reservation_station u_add_rs (
        .clk        (clk),
        .reset      (reset),
        .write      (add_write),
        .write_uop  (station_uop),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb),
        .take       (add_take),
        .full       (add_full),
        .pick_valid (add_pick_valid),
        .pick_uop   (add_pick_uop)
    );

    reservation_station u_mul_rs (
        .clk        (clk),
        .reset      (reset),
        .write      (mul_write),
        .write_uop  (station_uop),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb),
        .take       (mul_take),
        .full       (mul_full),
        .pick_valid (mul_pick_valid),
        .pick_uop   (mul_pick_uop)
    );

    reservation_station u_div_rs (
        .clk        (clk),
        .reset      (reset),
        .write      (div_write),
        .write_uop  (station_uop),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb),
        .take       (div_take),
        .full       (div_full),
        .pick_valid (div_pick_valid),
        .pick_uop   (div_pick_uop)
    );

    issue_stage u_issue (
        .clk             (clk),
        .reset           (reset),
        .add_pick_valid  (add_pick_valid),
        .mul_pick_valid  (mul_pick_valid),
        .div_pick_valid  (div_pick_valid),
        .add_pick_uop    (add_pick_uop),
        .mul_pick_uop    (mul_pick_uop),
        .div_pick_uop    (div_pick_uop),
        .add_take        (add_take),
        .mul_take        (mul_take),
        .div_take        (div_take),
        .add_issue_valid (add_issue_valid),
        .mul_issue_valid (mul_issue_valid),
        .div_issue_valid (div_issue_valid),
        .add_issue       (add_issue),
        .mul_issue       (mul_issue),
        .div_issue       (div_issue)
    );

endmodule

// File: tests/dispatch_chk.sv
`include "dispatch_consts.svh"

module dispatch_chk (
    input logic          clk,
    input logic          reset,
    input logic          dispatch_valid,
    input uop_pkg::uop_t dispatch_uop,
    input logic          add_write,
    input logic          mul_write,
    input logic          div_write,
    input logic          add_full,
    input logic          mul_full,
    input logic          div_full,
    input logic          add_issue_valid,
    input logic          mul_issue_valid,
    input logic          div_issue_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int         fail_count = 0;
    logic       target_full;
    logic [2:0] accepted;
    logic [2:0] strobes;
    logic [2:0] has_credit;
    int         credit [3];        // Accepted dispatches not yet issued

    assign accepted = {div_write && !div_full, mul_write && !mul_full, add_write && !add_full};
    assign strobes  = {div_issue_valid, mul_issue_valid, add_issue_valid};

    // Full level of the station this micro-op is routed to
    always_comb begin
        case (dispatch_uop.opcode)
            `OPC_MUL: target_full = mul_full;
            `OPC_DIV: target_full = div_full;
            default:  target_full = add_full;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < 3; k++) begin
            if (reset) begin
                credit[k] <= 0;
            end else begin
                credit[k] <= credit[k] + int'(accepted[k]) - int'(strobes[k]);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 3; k++) begin
            has_credit[k] = (credit[k] > 0);
        end
    end

    no_full_dispatch: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid |-> !target_full)
        else begin
            fail_count++;
            $error("Dispatch sent to a full station");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |=> (strobes == 3'b000))
        else begin
            fail_count++;
            $error("Issue strobe high in the cycle after reset");
        end

    // A unit never issues more micro-ops than were dispatched to it
    issue_needs_pick: assert property (@(posedge clk) disable iff (reset)
        (strobes & ~has_credit) == 3'b000)
        else begin
            fail_count++;
            $error("Issue strobe without an available pick");
        end

endmodule

bind dispatch_top dispatch_chk u_chk (
    .clk             (clk),
    .reset           (reset),
    .dispatch_valid  (dispatch_valid),
    .dispatch_uop    (dispatch_uop),
    .add_write       (add_write),
    .mul_write       (mul_write),
    .div_write       (div_write),
    .add_full        (add_full),
    .mul_full        (mul_full),
    .div_full        (div_full),
    .add_issue_valid (add_issue_valid),
    .mul_issue_valid (mul_issue_valid),
    .div_issue_valid (div_issue_valid)
);

// File: tests/dispatch_tb.sv
`include "dispatch_consts.svh"

module dispatch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import uop_pkg::*;
    import unit_pkg::*;

    localparam int      MAX_CYCLES = 400;   // Tests need about 130 cycles
    localparam int      STREAM_LEN = 40;
    localparam opcode_t OPC_ADDI   = 7'b0010011;

    typedef struct packed {
        unit_e  unit;
        issue_t pkt;
    } expect_t;

    logic         clk, reset, dispatch_valid, cdb_valid;
    logic         add_full, mul_full, div_full;
    logic         add_issue_valid, mul_issue_valid, div_issue_valid;
    uop_t         dispatch_uop;
    cdb_t         cdb;
    issue_t       add_issue, mul_issue, div_issue;
    logic [2:0]   valid_vec;
    logic [2:0]   full_vec;
    issue_t [2:0] pkt_vec;                  // Indexed by unit_e
    expect_t      exp_q [$];                // Oldest first
    logic [31:0]  rng_state = 32'h92fbe57a;
    int           cycles = 0;
    string        test_name = "reset";

    dispatch_top u_dut (.*);

    assign valid_vec = {div_issue_valid, mul_issue_valid, add_issue_valid};
    assign full_vec  = {div_full, mul_full, add_full};
    assign pkt_vec   = {div_issue, mul_issue, add_issue};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_with_failure($sformatf("Timeout after %0d cycles in %s", cycles, test_name));
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAILED %s: %s expected %b actual %b",
                test_name, what, exp, act));
        end
    endtask

    task automatic check_alu_op(input string what, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAILED %s: %s expected %b actual %b",
                test_name, what, exp, act));
        end
    endtask

    task automatic check_issue(input string what, input issue_t exp, input issue_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAILED %s: %s expected %h actual %h",
                test_name, what, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic unit_e unit_of(input opcode_t op);
        return (op == `OPC_MUL) ? UNIT_MUL : (op == `OPC_DIV) ? UNIT_DIV : UNIT_ADD;
    endfunction

    function automatic uop_t rand_uop(input opcode_t op, input logic [1:0] ready);
        logic [191:0] bits;
        uop_t         u;
        for (int i = 0; i < 6; i++) begin
            bits[32*i +: 32] = next_rand();
        end
        u = bits[$bits(uop_t)-1:0];
        u.opcode = op;
        u.ready  = ready;
        return u;
    endfunction

    // Packet the issue stage should produce for a fully ready micro-op
    function automatic issue_t expected_packet(input uop_t u);
        issue_t p;
        p.alu_a     = u.ctrl.alu_src1 ? u.pc : u.operand1;
        p.alu_b     = u.ctrl.alu_src2 ? u.immediate : u.operand2;
        p.func3     = u.func3;
        p.pc        = u.pc;
        p.rd        = u.rd;
        p.immediate = u.immediate;
        p.ctrl      = u.ctrl;
        if (unit_of(u.opcode) == UNIT_DIV) begin
            p.ctrl.alu_op = (u.ctrl.alu_op == `DIV_REM_ALUOP) ? 4'b0001 : 4'b0000;
        end
        return p;
    endfunction

    task automatic expect_issue(input uop_t u);
        expect_t e;
        e.unit = unit_of(u.opcode);
        e.pkt  = expected_packet(u);
        exp_q.push_back(e);
    endtask

    task automatic dispatch(input uop_t u);
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input preg_t tag, input word_t data);
        cdb_valid = 1'b1;
        cdb.tag   = tag;
        cdb.data  = data;
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    // Dispatch one ready micro-op and check its issue timing on its own unit
    task automatic send_ready(input uop_t u);
        int un;
        un = int'(unit_of(u.opcode));
        expect_issue(u);
        dispatch(u);
        check_bit("strobe one edge after dispatch", 1'b0, valid_vec[un]);
        @(negedge clk);
        check_bit("strobe two edges after dispatch", 1'b1, valid_vec[un]);
    endtask

    task automatic match_issue(input unit_e un);
        int idx;
        idx = -1;
        for (int i = exp_q.size() - 1; i >= 0; i--) begin
            if (exp_q[i].unit == un) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            stop_with_failure($sformatf("Unexpected issue on the %s unit in %s",
                un.name(), test_name));
        end else begin
            check_issue("issue packet", exp_q[idx].pkt, pkt_vec[int'(un)]);
            exp_q.delete(idx);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            for (int k = 0; k < 3; k++) begin
                if (valid_vec[k]) begin
                    match_issue(unit_e'(k));
                end
            end
            if (u_dut.u_chk.fail_count != 0) begin
                stop_with_failure("A bound assertion failed");
            end
        end
    end

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic reset_values();
        test_name = "reset";
        for (int k = 0; k < 3; k++) begin
            check_bit("issue strobe", 1'b0, valid_vec[k]);
            check_bit("full level", 1'b0, full_vec[k]);
            check_issue("issue packet", '0, pkt_vec[k]);
        end
    endtask

    task automatic unit_routing();
        test_name = "routing";
        send_ready(rand_uop(`OPC_MUL, 2'b11));
        send_ready(rand_uop(`OPC_DIV, 2'b11));
        send_ready(rand_uop(OPC_ADDI, 2'b11));
        drain();
    endtask

    task automatic remap_case(input opcode_t op, input alu_op_t op_in, input alu_op_t op_out);
        uop_t u;
        u = rand_uop(op, 2'b11);
        u.ctrl.alu_op = op_in;
        send_ready(u);
        check_alu_op("issued alu_op", op_out, pkt_vec[int'(unit_of(op))].ctrl.alu_op);
    endtask

    task automatic div_remap();
        test_name = "div_remap";
        remap_case(`OPC_DIV, `DIV_REM_ALUOP, 4'b0001);
        remap_case(`OPC_DIV, 4'b0110, 4'b0000);
        remap_case(`OPC_MUL, `DIV_REM_ALUOP, `DIV_REM_ALUOP);
        remap_case(OPC_ADDI, `DIV_REM_ALUOP, `DIV_REM_ALUOP);
        drain();
    endtask

    task automatic operand_wakeup();
        uop_t  u;
        word_t data;
        test_name = "wakeup";
        u = rand_uop(OPC_ADDI, 2'b01);   // Operand2 waits
        u.src2_tag      = 8'h2a;
        u.ctrl.alu_src2 = 1'b0;
        dispatch(u);
        broadcast(8'h15, next_rand());
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_bit("add strobe while waiting", 1'b0, add_issue_valid);
        end
        data = next_rand();
        u.operand2 = data;
        u.ready    = 2'b11;
        expect_issue(u);
        broadcast(8'h2a, data);
        check_bit("add strobe at broadcast edge", 1'b0, add_issue_valid);
        @(negedge clk);
        check_bit("add strobe after broadcast", 1'b1, add_issue_valid);
        drain();
    endtask

    task automatic fill_and_drain();
        uop_t  u [`RS_DEPTH];
        word_t data;
        test_name = "fill_drain";
        data = next_rand();
        for (int i = 0; i < `RS_DEPTH; i++) begin
            u[i] = rand_uop(OPC_ADDI, 2'b01);
            u[i].src2_tag = 8'h3c;
            check_bit("add_full while filling", 1'b0, add_full);
            dispatch(u[i]);
        end
        check_bit("add_full with station filled", 1'b1, add_full);
        for (int i = 0; i < `RS_DEPTH; i++) begin
            u[i].operand2 = data;
            u[i].ready    = 2'b11;
            expect_issue(u[i]);
        end
        broadcast(8'h3c, data);
        for (int i = 0; i < `RS_DEPTH; i++) begin
            @(negedge clk);
            check_bit("add strobe while draining", 1'b1, add_issue_valid);
        end
        check_bit("add_full after drain", 1'b0, add_full);
        drain();
    endtask

    task automatic random_stream();
        logic [31:0] r;
        opcode_t     op;
        uop_t        u;
        test_name = "random_stream";
        for (int n = 0; n < STREAM_LEN; n++) begin
            r  = next_rand();
            op = (r[1:0] == 2'd0) ? `OPC_MUL : (r[1:0] == 2'd1) ? `OPC_DIV : r[8:2];
            u  = rand_uop(op, 2'b11);
            while (full_vec[int'(unit_of(op))]) begin
                @(negedge clk);
            end
            expect_issue(u);
            dispatch(u);
            if (r[9]) begin
                @(negedge clk);   // Idle gap
            end
        end
        drain();
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        cdb_valid      = 1'b0;
        cdb            = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        reset_values();
        unit_routing();
        div_remap();
        operand_wakeup();
        fill_and_drain();
        random_stream();
        if (u_dut.u_chk.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure("A bound assertion failed");
        end
    end

endmodule

// File: dispatch_top.f
+incdir+include
hdl/uop_pkg.sv
hdl/unit_pkg.sv
hdl/dispatch_decoder.sv
hdl/reservation_station.sv
hdl/issue_stage.sv
hdl/dispatch_top.sv
tests/dispatch_chk.sv
tests/dispatch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dispatch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module dispatch_tb \
    -f dispatch_top.f -o dispatch_sim

# The log decides pass or fail, so a failing run must not stop the script here
./obj_dir/dispatch_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
